// ==== hw/cachePkg.sv ====
package cachePkg;

  // address and datapath widths
  localparam int AddrWidth = 32;
  localparam int Xlen      = 64;
  localparam int LineBits  = 256;

  // geometry
  localparam int NumSets      = 64;
  localparam int NumWays      = 2;
  localparam int OffsetBits   = 5;
  localparam int IndexBits    = 6;
  localparam int TagBits      = AddrWidth - IndexBits - OffsetBits;
  localparam int BeatsPerLine = LineBits / Xlen;
  localparam int MaskBits     = Xlen / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [TagBits-1:0]   tag_t;
  typedef logic [IndexBits-1:0] index_t;
  typedef logic [Xlen-1:0]      xlen_t;
  typedef logic [LineBits-1:0]  line_t;
  typedef logic [MaskBits-1:0]  mask_t;

  // miss handling walks WriteBack only for a dirty victim
  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    Miss,
    GetData,
    Replace
  } ctrlState_e;

endpackage

// ==== hw/busPkg.sv ====
package busPkg;

  // four beats per line, so two counter bits
  localparam int BeatBits = 2;

  typedef logic [BeatBits-1:0] beatCnt_t;

  // pipeline request opcode
  typedef enum logic {
    OpLoad,
    OpStore
  } memOp_e;

endpackage

// ==== hw/tagStore.sv ====
`timescale 1ns/1ps

module tagStore import cachePkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  index_t             index_i,
  input  tag_t               tag_i,
  input  logic               victimWay_i,
  input  logic [NumWays-1:0] fillEn_i,
  input  logic [NumWays-1:0] storeEn_i,
  output logic [NumWays-1:0] hitWay_o,
  output logic               victimDirty_o,
  output tag_t               victimTag_o
);

  tag_t                   tags  [NumWays][NumSets];
  logic [NumSets-1:0]     valid [NumWays];
  logic [NumSets-1:0]     dirty [NumWays];

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    // valid and dirty bits
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end else if (fillEn_i[w]) begin
        valid[w][index_i] <= 1'b1;
        dirty[w][index_i] <= 1'b0;
      end else if (storeEn_i[w]) begin
        dirty[w][index_i] <= 1'b1;
      end
    end

    // new tag comes with the refilled line
    always_ff @(posedge clk) begin
      if (fillEn_i[w]) begin
        tags[w][index_i] <= tag_i;
      end
    end

    assign hitWay_o[w] = valid[w][index_i] && (tags[w][index_i] == tag_i);
  end

  // victim lookup for the write-back decision and address
  assign victimDirty_o = valid[victimWay_i][index_i] && dirty[victimWay_i][index_i];
  assign victimTag_o   = tags[victimWay_i][index_i];

endmodule

// ==== hw/dataStore.sv ====
`timescale 1ns/1ps

module dataStore import cachePkg::*; (
  input  logic                  clk,
  input  index_t                index_i,
  input  logic [OffsetBits-1:0] offset_i,
  input  logic                  victimWay_i,
  input  logic [NumWays-1:0]    storeEn_i,
  input  xlen_t                 storeData_i,
  input  mask_t                 storeMask_i,
  input  logic [NumWays-1:0]    fillEn_i,
  input  line_t                 fillLine_i,
  input  logic [NumWays-1:0]    hitWay_i,
  output xlen_t                 rdData_o,
  output line_t                 victimLine_o
);

  line_t      lines [NumWays][NumSets];
  logic [1:0] wordSel;

  // which 64-bit word of the line
  assign wordSel = offset_i[OffsetBits-1:3];

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    always_ff @(posedge clk) begin
      if (fillEn_i[w]) begin
        lines[w][index_i] <= fillLine_i;
      end else if (storeEn_i[w]) begin
        // byte merge into the addressed word
        for (int b = 0; b < MaskBits; b++) begin
          if (storeMask_i[b]) begin
            lines[w][index_i][wordSel*Xlen + b*8 +: 8] <= storeData_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // load word of the hit way, quiet for a store
  always_comb begin
    rdData_o = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hitWay_i[w] && !storeEn_i[w]) begin
        rdData_o = rdData_o | lines[w][index_i][wordSel*Xlen +: Xlen];
      end
    end
  end

  assign victimLine_o = lines[victimWay_i][index_i];

endmodule

// ==== hw/refillBuffer.sv ====
`timescale 1ns/1ps

module refillBuffer import cachePkg::*; import busPkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  getData_i,
  input  logic  rdDataValid_i,
  input  xlen_t rdData_i,
  output line_t line_o
);

  beatCnt_t beatCnt;
  logic     beatEn;

  assign beatEn = getData_i && rdDataValid_i;

  // wraps to zero after the last beat, ready for the next refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatEn) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest beat lands in the lowest quarter
  always_ff @(posedge clk) begin
    if (beatEn) begin
      line_o[beatCnt*Xlen +: Xlen] <= rdData_i;
    end
  end

endmodule

// ==== hw/cacheCtrl.sv ====
`timescale 1ns/1ps

module cacheCtrl import cachePkg::*; import busPkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  memOp_e                reqOp_i,
  input  addr_t                 addr_i,
  input  xlen_t                 wrData_i,
  input  mask_t                 wrMask_i,
  input  logic [NumWays-1:0]    hitWay_i,
  input  logic                  victimDirty_i,
  input  tag_t                  victimTag_i,
  input  logic                  rdReady_i,
  input  logic                  rdLast_i,
  input  logic                  wrReady_i,
  output logic                  ready_o,
  output logic                  dataOk_o,
  output index_t                index_o,
  output tag_t                  tag_o,
  output logic [OffsetBits-1:0] offset_o,
  output xlen_t                 storeData_o,
  output mask_t                 storeMask_o,
  output logic [NumWays-1:0]    storeEn_o,
  output logic [NumWays-1:0]    fillEn_o,
  output logic                  victimWay_o,
  output logic                  getData_o,
  output logic                  rdValid_o,
  output addr_t                 rdAddr_o,
  output logic                  wrValid_o,
  output addr_t                 wrAddr_o
);

  ctrlState_e state;
  ctrlState_e nextState;
  memOp_e     opQ;
  addr_t      addrQ;
  logic       hit;
  logic       accept;
  logic       replBit;

  assign hit     = |hitWay_i;
  assign ready_o = (state == Idle) || (state == Compare && hit);
  assign accept  = reqValid_i && ready_o;

  // request latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opQ   <= OpLoad;
      addrQ <= '0;
    end else if (accept) begin
      opQ   <= reqOp_i;
      addrQ <= addr_i;
    end
  end

  // store payload, already shifted to its byte lanes
  always_ff @(posedge clk) begin
    if (accept) begin
      storeData_o <= wrData_i << {addr_i[2:0], 3'b000};
      storeMask_o <= wrMask_i << addr_i[2:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Idle:      if (accept) nextState = Compare;
      Compare: begin
        if (hit) begin
          nextState = accept ? Compare : Idle;
        end else begin
          nextState = victimDirty_i ? WriteBack : Miss;
        end
      end
      WriteBack: if (wrReady_i) nextState = Miss;
      Miss:      if (rdReady_i) nextState = GetData;
      GetData:   if (rdLast_i) nextState = Replace;
      // replay the request against the new line
      Replace:   nextState = Compare;
      default:   nextState = Idle;
    endcase
  end

  // toggling victim choice
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      replBit <= 1'b0;
    end else if (state == Replace) begin
      replBit <= ~replBit;
    end
  end

  assign index_o  = addrQ[OffsetBits +: IndexBits];
  assign tag_o    = addrQ[AddrWidth-1 -: TagBits];
  assign offset_o = addrQ[OffsetBits-1:0];

  assign dataOk_o    = (state == Compare) && hit;
  assign storeEn_o   = hitWay_i & {NumWays{dataOk_o && opQ == OpStore}};
  assign fillEn_o    = (state == Replace) ? (replBit ? 2'b10 : 2'b01) : 2'b00;
  assign victimWay_o = replBit;
  assign getData_o   = (state == GetData);

  // memory side strobes and line-aligned addresses
  assign rdValid_o = (state == Miss);
  assign rdAddr_o  = {tag_o, index_o, {OffsetBits{1'b0}}};
  assign wrValid_o = (state == WriteBack);
  assign wrAddr_o  = {victimTag_i, index_o, {OffsetBits{1'b0}}};

endmodule

// ==== hw/dcacheTop.sv ====
`timescale 1ns/1ps

module dcacheTop import cachePkg::*; import busPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  // pipeline side
  input  logic   reqValid_i,
  input  memOp_e reqOp_i,
  input  addr_t  addr_i,
  input  xlen_t  wrData_i,
  input  mask_t  wrMask_i,
  output logic   ready_o,
  output logic   dataOk_o,
  output xlen_t  rdData_o,
  // memory side
  output logic   rdValid_o,
  output addr_t  rdAddr_o,
  input  logic   rdReady_i,
  input  xlen_t  rdData_i,
  input  logic   rdDataValid_i,
  input  logic   rdLast_i,
  output logic   wrValid_o,
  output addr_t  wrAddr_o,
  output line_t  wrData_o,
  input  logic   wrReady_i
);

  index_t                index;
  tag_t                  tag;
  logic [OffsetBits-1:0] offset;
  xlen_t                 storeData;
  mask_t                 storeMask;
  logic [NumWays-1:0]    storeEn;
  logic [NumWays-1:0]    fillEn;
  logic [NumWays-1:0]    hitWay;
  logic                  victimWay;
  logic                  victimDirty;
  tag_t                  victimTag;
  logic                  getData;
  line_t                 fillLine;
  xlen_t                 wayData;

  cacheCtrl cacheCtrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqOp_i       (reqOp_i),
    .addr_i        (addr_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .hitWay_i      (hitWay),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .rdReady_i     (rdReady_i),
    .rdLast_i      (rdLast_i),
    .wrReady_i     (wrReady_i),
    .ready_o       (ready_o),
    .dataOk_o      (dataOk_o),
    .index_o       (index),
    .tag_o         (tag),
    .offset_o      (offset),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .storeEn_o     (storeEn),
    .fillEn_o      (fillEn),
    .victimWay_o   (victimWay),
    .getData_o     (getData),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .wrValid_o     (wrValid_o),
    .wrAddr_o      (wrAddr_o)
  );

  tagStore tagStore_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (index),
    .tag_i         (tag),
    .victimWay_i   (victimWay),
    .fillEn_i      (fillEn),
    .storeEn_i     (storeEn),
    .hitWay_o      (hitWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore dataStore_inst (
    .clk          (clk),
    .index_i      (index),
    .offset_i     (offset),
    .victimWay_i  (victimWay),
    .storeEn_i    (storeEn),
    .storeData_i  (storeData),
    .storeMask_i  (storeMask),
    .fillEn_i     (fillEn),
    .fillLine_i   (fillLine),
    .hitWay_i     (hitWay),
    .rdData_o     (wayData),
    .victimLine_o (wrData_o)
  );

  refillBuffer refillBuffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .getData_i     (getData),
    .rdDataValid_i (rdDataValid_i),
    .rdData_i      (rdData_i),
    .line_o        (fillLine)
  );

  // load data only shows in the dataOk cycle
  assign rdData_o = wayData & {Xlen{dataOk_o}};

endmodule

// ==== tests/memModel.sv ====
`timescale 1ns/1ps

module memModel import cachePkg::*; #(
  parameter int          MemAddrBits = 13,
  parameter logic [31:0] Seed        = 32'hec29ac48,
  parameter int          Delay       = 3
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rdValid_i,
  input  addr_t rdAddr_i,
  output logic  rdReady_o,
  output xlen_t rdData_o,
  output logic  rdDataValid_o,
  output logic  rdLast_o,
  input  logic  wrValid_i,
  input  addr_t wrAddr_i,
  input  line_t wrData_i,
  output logic  wrReady_o
);

  localparam int MemBytes = 1 << MemAddrBits;

  typedef logic [MemAddrBits-1:0] memIdx_t;

  logic [7:0] mem [MemBytes];
  addr_t      rdLineAddr;
  addr_t      wbAddr;
  line_t      wbLine;
  logic       streaming;
  int         beat;
  int         waitCnt;

  function automatic xlen_t readWord(input addr_t a);
    xlen_t w;
    for (int i = 0; i < 8; i++) begin
      w[i*8 +: 8] = mem[memIdx_t'(a + addr_t'(i))];
    end
    return w;
  endfunction

  // all outputs change on the falling edge, the cache samples on the rising one
  initial begin
    rdReady_o     = 1'b0;
    rdData_o      = '0;
    rdDataValid_o = 1'b0;
    rdLast_o      = 1'b0;
    wrReady_o     = 1'b0;
    rdLineAddr    = '0;
    wbAddr        = '0;
    wbLine        = '0;
    streaming     = 1'b0;
    beat          = 0;
    waitCnt       = 0;
    void'($urandom(Seed));
    for (int i = 0; i < MemBytes; i++) begin
      mem[memIdx_t'(i)] = 8'($urandom);
    end
    forever begin
      @(negedge clk);
      rdDataValid_o = 1'b0;
      rdLast_o      = 1'b0;
      if (!rst_n) begin
        rdReady_o = 1'b0;
        wrReady_o = 1'b0;
        streaming = 1'b0;
        waitCnt   = 0;
      end else if (wrReady_o) begin
        // line was taken at the last rising edge
        wrReady_o = 1'b0;
        for (int i = 0; i < LineBits / 8; i++) begin
          mem[memIdx_t'(wbAddr + addr_t'(i))] = wbLine[i*8 +: 8];
        end
      end else if (rdReady_o) begin
        rdReady_o = 1'b0;
        streaming = 1'b1;
        beat      = 0;
      end else if (streaming) begin
        // lowest beat first
        rdData_o      = readWord(rdLineAddr + addr_t'(beat * 8));
        rdDataValid_o = 1'b1;
        rdLast_o      = (beat == BeatsPerLine - 1);
        if (beat == BeatsPerLine - 1) begin
          streaming = 1'b0;
        end
        beat = beat + 1;
      end else if (wrValid_i || rdValid_i) begin
        if (waitCnt < Delay) begin
          waitCnt = waitCnt + 1;
        end else begin
          waitCnt = 0;
          if (wrValid_i) begin
            wrReady_o = 1'b1;
            wbAddr    = wrAddr_i;
            wbLine    = wrData_i;
          end else begin
            rdReady_o  = 1'b1;
            rdLineAddr = rdAddr_i;
          end
        end
      end
    end
  end

endmodule

// ==== tests/dcacheTb.sv ====
`timescale 1ns/1ps

module dcacheTb import cachePkg::*; import busPkg::*; ();

  localparam int MemAddrBits   = 13;
  localparam int MemBytes      = 1 << MemAddrBits;
  localparam int TimeoutCycles = 200;

  typedef logic [MemAddrBits-1:0] memIdx_t;

  // request fields plus the write-back the row should cause
  typedef struct packed {
    memOp_e op;
    addr_t  addr;
    xlen_t  data;
    mask_t  mask;
    logic   wbExp;
    addr_t  wbAddr;
  } stim_t;

  logic   clk;
  logic   rst_n;
  logic   reqValid;
  memOp_e reqOp;
  addr_t  reqAddr;
  xlen_t  wrData;
  mask_t  wrMask;
  logic   ready;
  logic   dataOk;
  xlen_t  rdData;
  logic   rdValid;
  addr_t  rdAddr;
  logic   rdReady;
  xlen_t  memRdData;
  logic   rdDataValid;
  logic   rdLast;
  logic   wrValid;
  addr_t  wrAddr;
  line_t  wbData;
  logic   wrReady;

  stim_t      stimQ [$];
  string      nameQ [$];
  logic [7:0] shadow [MemBytes];

  dcacheTop dcacheTop_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid),
    .reqOp_i       (reqOp),
    .addr_i        (reqAddr),
    .wrData_i      (wrData),
    .wrMask_i      (wrMask),
    .ready_o       (ready),
    .dataOk_o      (dataOk),
    .rdData_o      (rdData),
    .rdValid_o     (rdValid),
    .rdAddr_o      (rdAddr),
    .rdReady_i     (rdReady),
    .rdData_i      (memRdData),
    .rdDataValid_i (rdDataValid),
    .rdLast_i      (rdLast),
    .wrValid_o     (wrValid),
    .wrAddr_o      (wrAddr),
    .wrData_o      (wbData),
    .wrReady_i     (wrReady)
  );

  memModel #(.MemAddrBits(MemAddrBits)) memModel_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rdValid_i     (rdValid),
    .rdAddr_i      (rdAddr),
    .rdReady_o     (rdReady),
    .rdData_o      (memRdData),
    .rdDataValid_o (rdDataValid),
    .rdLast_o      (rdLast),
    .wrValid_i     (wrValid),
    .wrAddr_i      (wrAddr),
    .wrData_i      (wbData),
    .wrReady_o     (wrReady)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abortRun();
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkData(input string name, input xlen_t expVal, input xlen_t actVal);
    if (actVal !== expVal) begin
      $display("ERR %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkAddr(input string name, input addr_t expVal, input addr_t actVal);
    if (actVal !== expVal) begin
      $display("ERR %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkLine(input string name, input line_t expVal, input line_t actVal);
    if (actVal !== expVal) begin
      $display("ERR %s expected %h actual %h", name, expVal, actVal);
      abortRun();
    end
  endtask

  // aligned doubleword that holds the address
  function automatic xlen_t shadowWord(input addr_t a);
    xlen_t w;
    addr_t base;
    base = {a[AddrWidth-1:3], 3'b000};
    for (int i = 0; i < MaskBits; i++) begin
      w[i*8 +: 8] = shadow[memIdx_t'(base + addr_t'(i))];
    end
    return w;
  endfunction

  function automatic line_t shadowLine(input addr_t a);
    line_t l;
    addr_t base;
    base = {a[AddrWidth-1:OffsetBits], {OffsetBits{1'b0}}};
    for (int i = 0; i < LineBits / 8; i++) begin
      l[i*8 +: 8] = shadow[memIdx_t'(base + addr_t'(i))];
    end
    return l;
  endfunction

  // byte i of the store lands in lane i plus the low address bits
  task automatic applyStore(input addr_t a, input xlen_t d, input mask_t m);
    addr_t base;
    int    lane;
    base = {a[AddrWidth-1:3], 3'b000};
    for (int i = 0; i < MaskBits; i++) begin
      lane = int'(a[2:0]) + i;
      if (lane < MaskBits && m[i]) begin
        shadow[memIdx_t'(base + addr_t'(lane))] = d[i*8 +: 8];
      end
    end
  endtask

  task automatic addStim(input string name, input memOp_e op, input addr_t a, input xlen_t d,
                         input mask_t m, input logic wbExp, input addr_t wbAddr);
    stim_t s;
    s.op     = op;
    s.addr   = a;
    s.data   = d;
    s.mask   = m;
    s.wbExp  = wbExp;
    s.wbAddr = wbAddr;
    stimQ.push_back(s);
    nameQ.push_back(name);
  endtask

  // tags 0x000, 0x001 and 0x002 all share set 2
  task automatic buildTable();
    addStim("coldLoadUnaligned", OpLoad, 32'h0000_0125, '0, '0, 1'b0, '0);
    addStim("coldLoadSet2", OpLoad, 32'h0000_0040, '0, '0, 1'b0, '0);
    addStim("hitLoadUnaligned", OpLoad, 32'h0000_0043, '0, '0, 1'b0, '0);
    addStim("hitLoadWord3", OpLoad, 32'h0000_0058, '0, '0, 1'b0, '0);
    addStim("storeMasked", OpStore, 32'h0000_0048, 64'h1122_3344_5566_7788, 8'h5a, 1'b0, '0);
    addStim("loadAfterStore", OpLoad, 32'h0000_0048, '0, '0, 1'b0, '0);
    addStim("storeShifted", OpStore, 32'h0000_004b, 64'hdead_beef_cafe_f00d, 8'h0f, 1'b0, '0);
    addStim("loadAfterShifted", OpLoad, 32'h0000_0048, '0, '0, 1'b0, '0);
    addStim("fillSecondWay", OpLoad, 32'h0000_0840, '0, '0, 1'b0, '0);
    addStim("evictDirtyA", OpLoad, 32'h0000_1040, '0, '0, 1'b1, 32'h0000_0040);
    addStim("reloadEvictedA", OpLoad, 32'h0000_0048, '0, '0, 1'b0, '0);
    addStim("hitTagC", OpLoad, 32'h0000_1058, '0, '0, 1'b0, '0);
    addStim("storeMiss", OpStore, 32'h0000_0208, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, '0);
    addStim("loadStoreMiss", OpLoad, 32'h0000_0208, '0, '0, 1'b0, '0);
    addStim("storeMissB", OpStore, 32'h0000_0845, 64'h0000_0000_0000_a55a, 8'h03, 1'b0, '0);
    addStim("hitTagCAgain", OpLoad, 32'h0000_1040, '0, '0, 1'b0, '0);
    addStim("refillA", OpLoad, 32'h0000_0040, '0, '0, 1'b0, '0);
    addStim("hitTagB", OpLoad, 32'h0000_0840, '0, '0, 1'b0, '0);
    addStim("evictDirtyB", OpLoad, 32'h0000_1040, '0, '0, 1'b1, 32'h0000_0840);
    addStim("reloadEvictedB", OpLoad, 32'h0000_0845, '0, '0, 1'b0, '0);
  endtask

  // called on a falling edge, returns on the falling edge of the dataOk cycle
  task automatic runRequest(input string name, input stim_t s);
    xlen_t expWord;
    int    cycles;
    logic  wbSeen;
    logic  rdSeen;
    expWord = shadowWord(s.addr);
    cycles  = 0;
    while (!ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > TimeoutCycles) begin
        $display("%s: ready_o stayed low for %0d cycles", name, TimeoutCycles);
        abortRun();
      end
    end
    reqValid = 1'b1;
    reqOp    = s.op;
    reqAddr  = s.addr;
    wrData   = s.data;
    wrMask   = s.mask;
    @(negedge clk);
    reqValid = 1'b0;
    cycles   = 0;
    wbSeen   = 1'b0;
    rdSeen   = 1'b0;
    while (!dataOk) begin
      if (wrValid && !wbSeen) begin
        wbSeen = 1'b1;
        if (!s.wbExp) begin
          $display("%s: the cache wrote back a line although the victim was clean", name);
          abortRun();
        end
        checkAddr(name, s.wbAddr, wrAddr);
        checkLine(name, shadowLine(s.wbAddr), wbData);
      end
      // refill must ask for the line that holds the request
      if (rdValid && !rdSeen) begin
        rdSeen = 1'b1;
        checkAddr(name, {s.addr[AddrWidth-1:OffsetBits], {OffsetBits{1'b0}}}, rdAddr);
      end
      @(negedge clk);
      cycles++;
      if (cycles > TimeoutCycles) begin
        $display("%s: no dataOk_o pulse within %0d cycles", name, TimeoutCycles);
        abortRun();
      end
    end
    if (s.wbExp && !wbSeen) begin
      $display("%s: the dirty victim was never written back", name);
      abortRun();
    end
    if (s.op == OpLoad) begin
      checkData(name, expWord, rdData);
    end else begin
      checkData(name, '0, rdData);
      applyStore(s.addr, s.data, s.mask);
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    reqValid = 1'b0;
    reqOp    = OpLoad;
    reqAddr  = '0;
    wrData   = '0;
    wrMask   = '0;
    buildTable();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // shadow starts from the memory image
    for (int i = 0; i < MemBytes; i++) begin
      shadow[memIdx_t'(i)] = memModel_inst.mem[memIdx_t'(i)];
    end
    if (!ready || dataOk || rdValid || wrValid) begin
      $display("cache outputs are not at their reset values after reset");
      abortRun();
    end
    for (int n = 0; n < stimQ.size(); n++) begin
      runRequest(nameQ[n], stimQ[n]);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== build.f ====
hw/cachePkg.sv
hw/busPkg.sv
hw/tagStore.sv
hw/dataStore.sv
hw/refillBuffer.sv
hw/cacheCtrl.sv
hw/dcacheTop.sv
tests/memModel.sv
tests/dcacheTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the data cache testbench with Verilator

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f build.f --top-module dcacheTb -o simDcache
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/simDcache > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi
echo "simulation passed"
exit 0
